// ==== logic/am_align_defs.svh ====
`ifndef AM_ALIGN_DEFS_SVH
`define AM_ALIGN_DEFS_SVH

// Physical lanes in the receiver.
`define AM_N_LANES 4

// Distinct lane markers in the pattern table, also the match vector width.
`define AM_N_MARKERS 4

// Blocks from one marker to the next on a lane.
`define AM_PERIOD 16384

// Width of the invalid-marker limit and its counter.
`define AM_LIMIT_W 4

`endif

// ==== logic/am_align_pkg.sv ====
`include "am_align_defs.svh"

package am_align_pkg;

	localparam int AM_IDX_W = (`AM_N_MARKERS > 1) ? $clog2(`AM_N_MARKERS) : 1;

	localparam logic [1:0] AM_SH_CTRL = 2'b10; // Control block.
	localparam logic [1:0] AM_SH_DATA = 2'b01; // Data block.

	typedef struct packed {
		logic [1:0]  sync;
		logic [63:0] payload;
	} am_block_t;

	typedef logic [`AM_N_MARKERS-1:0] am_match_t;

	typedef logic [AM_IDX_W-1:0] am_marker_idx_t;

	typedef struct packed {
		logic           lock;
		am_marker_idx_t idx;
	} am_lane_status_t;

	typedef am_lane_status_t [`AM_N_LANES-1:0] am_lane_map_t;

	// Bytes 0..2 then 4..6, byte 0 in the top bits.
	localparam logic [47:0] AM_PATTERNS [`AM_N_MARKERS] = '{
		48'hC1_68_21_3E_97_DE,
		48'h9D_71_8E_62_8E_71,
		48'h59_4B_E8_A6_B4_17,
		48'h4D_95_7B_B2_6A_84
	};

	// Parity bytes 3 and 7 are skipped.
	function automatic logic [47:0] am_signature(input logic [63:0] payload);
		return {payload[7:0], payload[15:8], payload[23:16],
			payload[39:32], payload[47:40], payload[55:48]};
	endfunction

endpackage

// ==== logic/am_detector.sv ====
`timescale 1ns/1ps

`include "am_align_defs.svh"

module am_detector
	import am_align_pkg::*;
(
	input  logic      i_clock,
	input  logic      i_reset,
	input  logic      i_valid,
	input  am_block_t i_block,
	input  am_match_t i_match_mask,
	output logic      o_valid,
	output am_match_t o_match_vector,
	output logic      o_am_valid
);

	am_match_t   raw_match;
	logic [47:0] signature;
	logic        is_ctrl;

	// Marker bytes of the incoming block.
	assign signature = am_signature(i_block.payload);
	assign is_ctrl   = (i_block.sync == AM_SH_CTRL);

	always_comb
	begin
		for (int m = 0; m < `AM_N_MARKERS; m++)
		begin
			raw_match[m] = is_ctrl && (signature == AM_PATTERNS[m]); // One comparator per entry.
		end
	end

	// Strobe follows the input one cycle behind.
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= i_valid;
		end
	end

	// Result registers load only on an accepted block.
	always_ff @(posedge i_clock)
	begin
		if (i_valid)
		begin
			o_match_vector <= raw_match; // Raw, unmasked.
			o_am_valid     <= |(raw_match & i_match_mask); // Locked lane sees only its marker.
		end
	end

	// The table entries are distinct, so at most one entry can ever hit.
	a_single_match: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_valid |-> $onehot0(raw_match)
	);

endmodule

// ==== logic/am_lock_fsm.sv ====
`timescale 1ns/1ps

`include "am_align_defs.svh"

module am_lock_fsm
	import am_align_pkg::*;
#(
	parameter int P_PERIOD = `AM_PERIOD
)
(
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_enable,
	input  logic                   i_valid,
	input  logic                   i_block_lock,
	input  logic                   i_am_valid,
	input  logic [`AM_LIMIT_W-1:0] i_am_invalid_limit,
	input  am_match_t              i_match_vector,
	output am_match_t              o_match_mask,
	output logic                   o_ignore_sh,
	output logic                   o_am_lock
);

	localparam int TIMER_W = (P_PERIOD > 1) ? $clog2(P_PERIOD) : 1;

	typedef enum logic [1:0] {
		INIT,
		WAIT_1ST,
		WAIT_2ND,
		LOCKED
	} state_t;

	state_t                 state, next_state;
	am_match_t              match_mask, next_mask;
	logic                   ignore_sh, next_ignore;
	logic                   am_lock, next_lock;
	logic [`AM_LIMIT_W-1:0] invalid_count, next_count;
	logic [TIMER_W-1:0]     timer;
	logic                   timer_done;
	logic                   timer_restart;
	logic                   accept;
	logic [`AM_LIMIT_W:0]   count_inc;
	logic                   limit_hit;

	assign accept     = i_enable && i_valid;
	assign timer_done = (timer == TIMER_W'(P_PERIOD - 1)); // P_PERIOD blocks since restart.
	assign count_inc  = {1'b0, invalid_count} + 1'b1;
	assign limit_hit  = (count_inc >= {1'b0, i_am_invalid_limit});

	always_comb
	begin
		next_state    = state;
		next_mask     = match_mask;
		next_ignore   = ignore_sh;
		next_lock     = am_lock;
		next_count    = invalid_count;
		timer_restart = 1'b0;
		if (!i_block_lock)
		begin
			next_state  = INIT; // Lost block lock.
			next_mask   = '1;
			next_ignore = 1'b0;
			next_lock   = 1'b0;
			next_count  = '0;
		end
		else
		begin
			case (state)
				INIT:
				begin
					next_state = WAIT_1ST;
				end
				WAIT_1ST:
				begin
					if (i_am_valid)
					begin
						next_mask     = i_match_vector; // Narrow to the found marker.
						next_ignore   = 1'b1;
						timer_restart = 1'b1;
						next_state    = WAIT_2ND;
					end
				end
				WAIT_2ND:
				begin
					if (timer_done && i_am_valid)
					begin
						next_lock     = 1'b1;
						next_count    = '0;
						timer_restart = 1'b1;
						next_state    = LOCKED;
					end
					else if (timer_done)
					begin
						next_mask   = '1; // Re-arm on any marker.
						next_ignore = 1'b0;
						next_state  = WAIT_1ST;
					end
				end
				LOCKED:
				begin
					if (timer_done)
					begin
						timer_restart = 1'b1;
						if (i_am_valid)
						begin
							next_count = '0;
						end
						else if (limit_hit)
						begin
							next_lock   = 1'b0; // Too many misses in a row.
							next_mask   = '1;
							next_ignore = 1'b0;
							next_count  = '0;
							next_state  = WAIT_1ST;
						end
						else
						begin
							next_count = count_inc[`AM_LIMIT_W-1:0];
						end
					end
				end
				default:
				begin
					next_state = INIT;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state         <= INIT;
			match_mask    <= '1;
			ignore_sh     <= 1'b0;
			am_lock       <= 1'b0;
			invalid_count <= '0;
			timer         <= '0;
		end
		else if (accept)
		begin
			state         <= next_state;
			match_mask    <= next_mask;
			ignore_sh     <= next_ignore;
			am_lock       <= next_lock;
			invalid_count <= next_count;
			timer         <= (timer_restart || timer_done) ? '0 : timer + 1'b1;
		end
	end

	assign o_match_mask = match_mask;
	assign o_ignore_sh  = ignore_sh;
	assign o_am_lock    = am_lock;

	// Lock rests on a single marker taken from the detector.
	a_lock_onehot_mask: assert property (
		@(posedge i_clock) disable iff (i_reset)
		am_lock |-> $onehot(match_mask)
	);

	a_lock_ignore_sh: assert property (
		@(posedge i_clock) disable iff (i_reset)
		am_lock |-> ignore_sh
	);

endmodule

// ==== logic/lane_lock_status.sv ====
`timescale 1ns/1ps

`include "am_align_defs.svh"

module lane_lock_status
	import am_align_pkg::*;
(
	input  logic                              i_clock,
	input  logic                              i_reset,
	input  logic [`AM_N_LANES-1:0]            i_lock,
	input  am_match_t [`AM_N_LANES-1:0]       i_masks,
	output am_lane_map_t                      o_lane_map,
	output logic                              o_all_locked,
	output logic                              o_map_error
);

	am_lane_map_t lane_map_next;
	logic         dup_found;

	// One-hot mask to marker index, unlocked lanes read zero.
	always_comb
	begin
		lane_map_next = '0;
		for (int l = 0; l < `AM_N_LANES; l++)
		begin
			lane_map_next[l].lock = i_lock[l];
			if (i_lock[l])
			begin
				for (int m = 0; m < `AM_N_MARKERS; m++)
				begin
					if (i_masks[l][m])
					begin
						lane_map_next[l].idx = am_marker_idx_t'(m);
					end
				end
			end
		end
	end

	// Any two locked lanes on the same marker.
	always_comb
	begin
		dup_found = 1'b0;
		for (int a = 0; a < `AM_N_LANES; a++)
		begin
			for (int b = a + 1; b < `AM_N_LANES; b++)
			begin
				if (i_lock[a] && i_lock[b] &&
					(lane_map_next[a].idx == lane_map_next[b].idx))
				begin
					dup_found = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_lane_map   <= '0;
			o_all_locked <= 1'b0;
			o_map_error  <= 1'b0;
		end
		else
		begin
			o_lane_map   <= lane_map_next;
			o_all_locked <= &i_lock;
			o_map_error  <= dup_found;
		end
	end

endmodule

// ==== logic/am_align_rx.sv ====
`timescale 1ns/1ps

`include "am_align_defs.svh"

module am_align_rx
	import am_align_pkg::*;
#(
	parameter int P_PERIOD = `AM_PERIOD
)
(
	input  logic                         i_clock,
	input  logic                         i_reset,
	input  logic                         i_enable,
	input  logic                         i_block_valid,
	input  am_block_t [`AM_N_LANES-1:0]  i_blocks,
	input  logic [`AM_N_LANES-1:0]       i_block_lock,
	input  logic [`AM_LIMIT_W-1:0]       i_am_invalid_limit,
	output logic [`AM_N_LANES-1:0]       o_ignore_sh,
	output am_lane_map_t                 o_lane_map,
	output logic                         o_all_locked,
	output logic                         o_map_error
);

	logic [`AM_N_LANES-1:0]      det_valid;
	logic [`AM_N_LANES-1:0]      det_am_valid;
	am_match_t [`AM_N_LANES-1:0] det_match;
	am_match_t [`AM_N_LANES-1:0] lane_mask;
	logic [`AM_N_LANES-1:0]      lane_lock;

	for (genvar l = 0; l < `AM_N_LANES; l++)
	begin : g_lane
		am_detector detector_i (
			.i_clock        (i_clock),
			.i_reset        (i_reset),
			.i_valid        (i_block_valid),
			.i_block        (i_blocks[l]),
			.i_match_mask   (lane_mask[l]),
			.o_valid        (det_valid[l]),
			.o_match_vector (det_match[l]),
			.o_am_valid     (det_am_valid[l])
		);

		am_lock_fsm #(
			.P_PERIOD (P_PERIOD)
		) lock_fsm_i (
			.i_clock            (i_clock),
			.i_reset            (i_reset),
			.i_enable           (i_enable),
			.i_valid            (det_valid[l]),
			.i_block_lock       (i_block_lock[l]),
			.i_am_valid         (det_am_valid[l]),
			.i_am_invalid_limit (i_am_invalid_limit),
			.i_match_vector     (det_match[l]),
			.o_match_mask       (lane_mask[l]),
			.o_ignore_sh        (o_ignore_sh[l]),
			.o_am_lock          (lane_lock[l])
		);
	end

	lane_lock_status status_i (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_lock       (lane_lock),
		.i_masks      (lane_mask),
		.o_lane_map   (o_lane_map),
		.o_all_locked (o_all_locked),
		.o_map_error  (o_map_error)
	);

endmodule

// ==== tb/am_align_tb.sv ====
`timescale 1ns/1ps

`include "am_align_defs.svh"

module am_align_tb
	import am_align_pkg::*;
();

	localparam int PERIOD     = 32;
	localparam int LIMIT      = 3;
	localparam int N_TESTS    = 6;
	localparam int N_PER      = 15; // Periods per test at most.
	localparam int TIMEOUT    = N_TESTS * N_PER * PERIOD * 2;
	localparam int FREEZE_LEN = 40;
	localparam int K_MARK     = 0;
	localparam int K_MISS     = 1;
	localparam int K_CORRUPT  = 2;
	localparam int K_FOREIGN  = 3;
	localparam int S_INIT     = 0;
	localparam int S_WAIT1    = 1;
	localparam int S_WAIT2    = 2;
	localparam int S_LOCKED   = 3;

	logic                        clock;
	logic                        reset;
	logic                        enable;
	logic                        block_valid;
	am_block_t [`AM_N_LANES-1:0] blocks;
	logic [`AM_N_LANES-1:0]      block_lock;
	logic [`AM_LIMIT_W-1:0]      invalid_limit;
	logic [`AM_N_LANES-1:0]      ignore_sh;
	am_lane_map_t                lane_map;
	logic                        all_locked;
	logic                        map_error;

	integer seed;
	int     cycles = 0;
	int     pos;
	int     freeze_at;
	int     freeze_left;
	int     drop_lane;
	int     drop_at;
	int     drop_left;
	int     lane_idx [`AM_N_LANES];
	int     phase [`AM_N_LANES];
	int     kind_tab [`AM_N_LANES][N_PER];

	// Lock model with one entry per lane.
	int           m_state [`AM_N_LANES];
	am_match_t    m_mask [`AM_N_LANES];
	logic         m_ign [`AM_N_LANES];
	logic         m_lock [`AM_N_LANES];
	int           m_miss [`AM_N_LANES];
	int           m_since [`AM_N_LANES];
	am_match_t    pipe_match [`AM_N_LANES];
	logic         pipe_amv [`AM_N_LANES];
	logic         pipe_valid;
	am_lane_map_t exp_map_d; // Status lags the FSM by one edge.

	am_align_rx #(
		.P_PERIOD (PERIOD)
	) dut_i (
		.i_clock            (clock),
		.i_reset            (reset),
		.i_enable           (enable),
		.i_block_valid      (block_valid),
		.i_blocks           (blocks),
		.i_block_lock       (block_lock),
		.i_am_invalid_limit (invalid_limit),
		.o_ignore_sh        (ignore_sh),
		.o_lane_map         (lane_map),
		.o_all_locked       (all_locked),
		.o_map_error        (map_error)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	always @(posedge clock)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT)
			stop_with_failure("timeout: the run went past its cycle limit");
	end

	task automatic check_lane_map(input am_lane_map_t got, input am_lane_map_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("error: o_lane_map got 0x%h expected 0x%h", got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string name);
		if (got !== exp)
			stop_with_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	function automatic am_match_t match_of(input am_block_t b);
		logic [47:0] sig;
		am_match_t   hits;
		for (int k = 0; k < 6; k++)
			sig[47 - 8 * k -: 8] = b.payload[8 * (k + k / 3) +: 8]; // Skips bytes 3 and 7.
		for (int m = 0; m < `AM_N_MARKERS; m++)
			hits[m] = (b.sync == AM_SH_CTRL) && (sig == AM_PATTERNS[m]);
		return hits;
	endfunction

	function automatic am_block_t block_for(input int l, input int p);
		am_block_t   b;
		logic [47:0] sig;
		int          kind;
		kind = (p / PERIOD < N_PER) ? kind_tab[l][p / PERIOD] : K_MARK;
		b.payload = {$random(seed), $random(seed)};
		b.sync = AM_SH_DATA;
		if (p % PERIOD == phase[l] && kind != K_MISS)
		begin
			sig = AM_PATTERNS[(kind == K_FOREIGN) ? (lane_idx[l] + 1) % `AM_N_MARKERS
				: lane_idx[l]];
			b.sync = AM_SH_CTRL;
			b.payload[23:0]  = {sig[31:24], sig[39:32], sig[47:40]};
			b.payload[55:32] = {sig[7:0], sig[15:8], sig[23:16]};
			if (kind == K_CORRUPT)
				b.payload[15:8] = ~b.payload[15:8]; // Broken marker byte.
		end
		return b;
	endfunction

	function automatic am_lane_map_t model_map();
		am_lane_map_t map;
		map = '0;
		for (int l = 0; l < `AM_N_LANES; l++)
		begin
			map[l].lock = m_lock[l];
			for (int m = 0; m < `AM_N_MARKERS; m++)
				if (m_lock[l] && m_mask[l][m])
					map[l].idx = am_marker_idx_t'(m);
		end
		return map;
	endfunction

	function automatic logic map_has_dup(input am_lane_map_t map);
		logic dup;
		dup = 1'b0;
		for (int a = 0; a < `AM_N_LANES; a++)
			for (int b = 0; b < a; b++)
				dup |= map[a].lock && map[b].lock && (map[a].idx == map[b].idx);
		return dup;
	endfunction

	task automatic reopen(input int l);
		m_mask[l]  = '1;
		m_ign[l]   = 1'b0;
		m_state[l] = S_WAIT1;
	endtask

	task automatic model_lane(input int l, input logic bl, input am_match_t hit, input logic amv);
		logic done;
		logic restart;
		done    = (m_since[l] == PERIOD - 1);
		restart = 1'b0;
		if (!bl)
		begin
			reopen(l);
			m_state[l] = S_INIT;
			m_lock[l]  = 1'b0;
			m_miss[l]  = 0;
		end
		else
		begin
			case (m_state[l])
				S_INIT: m_state[l] = S_WAIT1;
				S_WAIT1:
					if (amv)
					begin
						m_mask[l]  = hit;
						m_ign[l]   = 1'b1;
						m_state[l] = S_WAIT2;
						restart    = 1'b1;
					end
				S_WAIT2:
					if (done && amv)
					begin
						m_lock[l]  = 1'b1;
						m_miss[l]  = 0;
						m_state[l] = S_LOCKED;
						restart    = 1'b1;
					end
					else if (done)
						reopen(l);
				default:
					if (done)
					begin
						restart   = 1'b1;
						m_miss[l] = amv ? 0 : m_miss[l] + 1;
						if (m_miss[l] >= LIMIT)
						begin
							reopen(l);
							m_lock[l] = 1'b0;
							m_miss[l] = 0;
						end
					end
			endcase
		end
		m_since[l] = (restart || done) ? 0 : m_since[l] + 1;
	endtask

	task automatic compare_outputs();
		check_lane_map(lane_map, exp_map_d);
		check_flag(all_locked, &{exp_map_d[3].lock, exp_map_d[2].lock, exp_map_d[1].lock,
			exp_map_d[0].lock}, "o_all_locked");
		check_flag(map_error, map_has_dup(exp_map_d), "o_map_error");
		for (int l = 0; l < `AM_N_LANES; l++)
			check_flag(ignore_sh[l], m_ign[l], $sformatf("o_ignore_sh[%0d]", l));
	endtask

	task automatic step_cycle();
		logic                   en;
		logic [`AM_N_LANES-1:0] bl;
		am_match_t              old_mask;
		if (pos % PERIOD == PERIOD - 1)
			compare_outputs(); // Outputs show the previous edge.
		en = 1'b1;
		bl = '1;
		if (freeze_left > 0 || pos == freeze_at)
		begin
			en          = 1'b0;
			freeze_left = (freeze_left > 0) ? freeze_left - 1 : FREEZE_LEN - 1;
			freeze_at   = -1;
			pos         = pos - 1; // Resend the block the FSM skips.
		end
		if (drop_left > 0 || pos == drop_at)
		begin
			bl[drop_lane] = 1'b0;
			drop_left     = (drop_left > 0) ? drop_left - 1 : 2;
			drop_at       = -1;
		end
		enable     = en;
		block_lock = bl;
		for (int l = 0; l < `AM_N_LANES; l++)
			blocks[l] = block_for(l, pos);
		pos++;
		exp_map_d = model_map();
		for (int l = 0; l < `AM_N_LANES; l++)
		begin
			old_mask = m_mask[l];
			if (en && pipe_valid)
				model_lane(l, bl[l], pipe_match[l], pipe_amv[l]);
			pipe_match[l] = match_of(blocks[l]);
			pipe_amv[l]   = |(pipe_match[l] & old_mask);
		end
		pipe_valid = 1'b1;
		@(negedge clock);
	endtask

	task automatic start_test(input logic dup);
		int j;
		int t;
		reset      = 1'b1;
		enable     = 1'b1;
		block_lock = '1;
		blocks     = '0;
		repeat (4) @(negedge clock);
		reset = 1'b0;
		for (int l = 0; l < `AM_N_LANES; l++)
			lane_idx[l] = l % `AM_N_MARKERS;
		for (int i = `AM_N_LANES - 1; i > 0; i--)
		begin
			j           = $unsigned($random(seed)) % (i + 1); // Shuffle of marker indices.
			t           = lane_idx[i];
			lane_idx[i] = lane_idx[j];
			lane_idx[j] = t;
		end
		if (dup)
			lane_idx[1] = lane_idx[0];
		for (int l = 0; l < `AM_N_LANES; l++)
		begin
			phase[l]   = 1 + $unsigned($random(seed)) % 23;
			m_state[l] = S_INIT;
			m_mask[l]  = '1;
			m_ign[l]   = 1'b0;
			m_lock[l]  = 1'b0;
			m_miss[l]  = 0;
			m_since[l] = 0;
			for (int p = 0; p < N_PER; p++)
				kind_tab[l][p] = K_MARK;
		end
		pos         = 0;
		freeze_at   = -1;
		freeze_left = 0;
		drop_at     = -1;
		drop_left   = 0;
		pipe_valid  = 1'b0;
		exp_map_d   = '0;
	endtask

	task automatic run_periods(input int n);
		while (pos < n * PERIOD)
			step_cycle();
	endtask

	initial
	begin
		seed          = 40;
		reset         = 1'b1;
		enable        = 1'b1;
		block_valid   = 1'b1;
		block_lock    = '1;
		blocks        = '0;
		invalid_limit = `AM_LIMIT_W'(LIMIT);
		@(negedge clock);
		start_test(1'b0); // Clean markers.
		run_periods(4);
		check_flag(all_locked, 1'b1, "o_all_locked");
		start_test(1'b0); // Second marker missing.
		for (int l = 0; l < `AM_N_LANES; l++)
			kind_tab[l][1] = K_MISS;
		run_periods(3);
		check_flag(all_locked, 1'b0, "o_all_locked");
		run_periods(5);
		check_flag(all_locked, 1'b1, "o_all_locked");
		start_test(1'b0); // Corrupted markers while locked.
		for (int l = 0; l < `AM_N_LANES; l++)
			for (int p = 2; p < 8; p++)
				kind_tab[l][p] = (p == 4) ? K_MARK : K_CORRUPT;
		run_periods(7);
		check_flag(all_locked, 1'b1, "o_all_locked");
		run_periods(8);
		check_flag(all_locked, 1'b0, "o_all_locked");
		start_test(1'b0); // Foreign marker on lane 0.
		for (int p = 2; p < 5; p++)
			kind_tab[0][p] = K_FOREIGN;
		run_periods(6);
		check_flag(lane_map[0].lock, 1'b0, "o_lane_map[0].lock");
		check_flag(all_locked, 1'b0, "o_all_locked");
		start_test(1'b1); // Two lanes on one marker.
		run_periods(3);
		check_flag(map_error, 1'b1, "o_map_error");
		check_flag(all_locked, 1'b1, "o_all_locked");
		start_test(1'b0); // Block lock drop and then a long enable freeze.
		drop_lane = $unsigned($random(seed)) % `AM_N_LANES;
		drop_at   = 2 * PERIOD + 28;
		freeze_at = 5 * PERIOD + 28;
		run_periods(3);
		check_flag(ignore_sh[drop_lane], 1'b0, "o_ignore_sh");
		check_flag(lane_map[drop_lane].lock, 1'b0, "o_lane_map.lock");
		run_periods(10);
		check_flag(all_locked, 1'b1, "o_all_locked");
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+logic
logic/am_align_pkg.sv
logic/am_detector.sv
logic/am_lock_fsm.sv
logic/lane_lock_status.sv
logic/am_align_rx.sv
tb/am_align_tb.sv

// ==== Bender.yml ====
package:
  name: am_align

sources:
  - include_dirs:
      - logic
    files:
      - logic/am_align_pkg.sv
      - logic/am_detector.sv
      - logic/am_lock_fsm.sv
      - logic/lane_lock_status.sv
      - logic/am_align_rx.sv
      - target: simulation
        files:
          - tb/am_align_tb.sv
